// File: rtl/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic eret,
    input  logic ds_allowin,         // decode takes the current item
    input  logic addr_ok,            // memory took the request
    input  logic data_ok,            // memory word returns
    input  logic nextpc_misaligned,
    output logic inst_valid,         // request level to memory
    output logic npc_flow,
    output logic flush_pend,
    output logic pc_load,            // out stage takes nextpc
    output logic fs_to_ds_valid
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;
    logic                    can_issue;
    logic                    accept;
    logic                    adel_load;

    // only one word in flight, and decode must be able to take it on return
    assign can_issue = (state != fetch_pkg::wait_data) & ds_allowin;

    // bad address never reaches memory
    assign inst_valid = can_issue & ~nextpc_misaligned;
    assign accept     = inst_valid & addr_ok;

    // misaligned pc goes straight to decode as an exception item
    assign adel_load = can_issue & nextpc_misaligned;

    // a word returning under eret belongs to the old stream, drop it
    assign pc_load = (data_ok & ~eret) | adel_load;

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::idle: begin
                if (accept) begin
                    state_next = fetch_pkg::wait_data;
                end else if (inst_valid) begin
                    state_next = fetch_pkg::wait_addr;
                end
            end
            fetch_pkg::wait_addr: begin
                if (accept) begin
                    state_next = fetch_pkg::wait_data;
                end else if (~inst_valid) begin
                    state_next = fetch_pkg::idle;  // request withdrawn
                end
            end
            fetch_pkg::wait_data: begin
                if (data_ok) begin
                    state_next = fetch_pkg::idle;
                end
            end
            default: state_next = fetch_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // fs_pc updated last cycle, next address may advance now
    always_ff @(posedge clk) begin
        if (reset) begin
            npc_flow <= 1'b0;
        end else begin
            npc_flow <= pc_load;
        end
    end

    // exception vector stays selected until a word comes back
    // set wins over clear when both land together
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_pend <= 1'b0;
        end else if (flush & ~eret) begin
            flush_pend <= 1'b1;
        end else if (data_ok | eret) begin
            flush_pend <= 1'b0;  // eret overrides the pending entry
        end
    end

    // set on load, hold while decode is full, clear once taken
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_to_ds_valid <= 1'b0;
        end else if (pc_load) begin
            fs_to_ds_valid <= 1'b1;
        end else if (ds_allowin) begin
            fs_to_ds_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_out_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pc_load,
    input  logic                  flush,
    input  logic                  flush_pend,
    input  fetch_pkg::addr_t      nextpc,
    input  fetch_pkg::inst_t      rdata,         // memory word, valid with data_ok
    input  logic                  bd,            // delay slot flag from decode
    output fetch_pkg::fs_to_ds_t  fs_to_ds_bus,
    output fetch_pkg::addr_t      fs_pc
);

    fetch_pkg::inst_t inst_q;  // word held for decode
    logic             bd_q;
    logic             adel;

    // pc of the item presented to decode
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= fetch_pkg::RESET_PC;
        end else if (pc_load) begin
            fs_pc <= nextpc;
        end
    end

    // payload, follows pc_load only
    always_ff @(posedge clk) begin
        if (pc_load) begin
            inst_q <= rdata;
            bd_q   <= bd;
        end
    end

    // exception travels with the pc, not with the request
    assign adel = (fs_pc[1:0] != 2'b00);

    always_comb begin
        fs_to_ds_bus.ex       = adel;
        fs_to_ds_bus.exc_code = adel ? fetch_pkg::EXC_ADEL : fetch_pkg::EXC_NONE;
        fs_to_ds_bus.bd       = bd_q;
        // zero is a nop, keeps a stale branch out of decode
        if (adel | flush | flush_pend) begin
            fs_to_ds_bus.inst = '0;
        end else begin
            fs_to_ds_bus.inst = inst_q;
        end
        fs_to_ds_bus.pc       = fs_pc;
    end

endmodule

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // widths that carry a meaning
    typedef logic [31:0] addr_t;          // fetch address
    typedef logic [31:0] inst_t;          // instruction word
    typedef logic [4:0]  exc_code_t;      // cp0 cause code
    typedef logic [19:0] cache_tag_t;     // addr[31:12]
    typedef logic [7:0]  cache_index_t;   // addr[11:4]
    typedef logic [3:0]  cache_offset_t;  // addr[3:0]

    // pc register value in reset, one word below boot
    localparam addr_t RESET_PC = 32'hbfbffffc;
    // general exception entry
    localparam addr_t EXC_VECTOR = 32'hbfc00380;

    localparam exc_code_t EXC_ADEL = 5'h04;  // address error on load/fetch
    localparam exc_code_t EXC_NONE = 5'h1f;  // all ones, nothing raised

    localparam int ROM_WORDS = 32;  // instruction image depth

    // branch info coming back from decode
    typedef struct packed {
        logic  bd;         // next fetch sits in a delay slot
        logic  br_stall;   // decode cannot resolve the branch yet
        logic  br_taken;
        addr_t br_target;
    } br_bus_t;

    // fetch to decode, 71 bits
    typedef struct packed {
        logic      ex;        // 70
        exc_code_t exc_code;  // 69:65
        logic      bd;        // 64
        inst_t     inst;      // 63:32
        addr_t     pc;        // 31:0
    } fs_to_ds_t;

    // request address as the icache sees it
    typedef struct packed {
        cache_tag_t    tag;
        cache_index_t  index;
        cache_offset_t offset;
    } inst_req_t;

    // request fsm of the fetch stage
    typedef enum logic [1:0] {
        idle,       // nothing asked
        wait_addr,  // request up, not yet taken
        wait_data   // taken, word due this cycle
    } fetch_state_t;

endpackage

`default_nettype wire

// File: rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::br_bus_t    br_bus,          // from decode
    input  logic                  flush,
    input  logic                  eret,
    input  fetch_pkg::addr_t      epc,
    input  logic                  mfc0_stall,
    input  logic                  ds_allowin,
    output logic                  fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t  fs_to_ds_bus
);

    fetch_pkg::addr_t     nextpc;
    fetch_pkg::addr_t     fs_pc;
    fetch_pkg::inst_t     rdata;
    fetch_pkg::inst_req_t inst_req;
    logic                 nextpc_misaligned;
    logic                 npc_flow;
    logic                 flush_pend;
    logic                 pc_load;
    logic                 inst_valid;
    logic                 addr_ok;
    logic                 data_ok;

    // icache view of the fetch address
    assign {inst_req.tag, inst_req.index, inst_req.offset} = nextpc;

    fetch_ctrl u_ctrl (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .eret              (eret),
        .ds_allowin        (ds_allowin),
        .addr_ok           (addr_ok),
        .data_ok           (data_ok),
        .nextpc_misaligned (nextpc_misaligned),
        .inst_valid        (inst_valid),
        .npc_flow          (npc_flow),
        .flush_pend        (flush_pend),
        .pc_load           (pc_load),
        .fs_to_ds_valid    (fs_to_ds_valid)
    );

    next_pc_unit u_npc (
        .clk               (clk),
        .reset             (reset),
        .eret              (eret),
        .flush             (flush),
        .flush_pend        (flush_pend),
        .npc_flow          (npc_flow),
        .mfc0_stall        (mfc0_stall),
        .epc               (epc),
        .br_bus            (br_bus),
        .fs_pc             (fs_pc),
        .nextpc            (nextpc),
        .nextpc_misaligned (nextpc_misaligned)
    );

    fetch_out_stage u_out (
        .clk          (clk),
        .reset        (reset),
        .pc_load      (pc_load),
        .flush        (flush),
        .flush_pend   (flush_pend),
        .nextpc       (nextpc),
        .rdata        (rdata),
        .bd           (br_bus.bd),  // decode marks the slot being fetched
        .fs_to_ds_bus (fs_to_ds_bus),
        .fs_pc        (fs_pc)
    );

    // stands in for the icache
    inst_rom u_rom (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_req   (inst_req),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: rtl/inst_rom.hex
// one 32-bit instruction word per line, word 0 at the boot address
3c08bfc0
25080010
24090001
240a0002
012a5821
ad0b0000
8d0c0000
11800003
00000000
240d0003
01ad7023
000e7880
3c10bfc0
26100380
8e110000
02208821
24120004
0251982a
1260fff0
00000000
40086000
3c09ffbf
3529ffff
01094024
40886000
42000018
00000000
0bf00000
24140005
0294a825
ae150004
1000ffe1

// File: rtl/inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,  // request level
    input  fetch_pkg::inst_req_t  inst_req,
    output logic                  addr_ok,     // taken this cycle when valid
    output logic                  data_ok,     // word on rdata
    output fetch_pkg::inst_t      rdata
);

    fetch_pkg::inst_t                        mem [0:fetch_pkg::ROM_WORDS-1];
    fetch_pkg::addr_t                        req_addr;
    logic [$clog2(fetch_pkg::ROM_WORDS)-1:0] word_idx;
    logic                                    data_due;  // one word owed next cycle

    initial begin
        $readmemh("rtl/inst_rom.hex", mem);
    end

    // tag/index/offset back into a flat byte address
    assign req_addr = {inst_req.tag, inst_req.index, inst_req.offset};
    assign word_idx = req_addr[6:2];  // image wraps every 128 bytes

    // single outstanding request
    assign addr_ok = ~data_due;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_due <= 1'b0;
        end else begin
            data_due <= inst_valid & addr_ok;
        end
    end

    assign data_ok = data_due;

    // read on acceptance, word holds until the next one
    always_ff @(posedge clk) begin
        if (inst_valid & addr_ok) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/next_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                eret,        // return from exception
    input  logic                flush,       // exception seen this cycle
    input  logic                flush_pend,  // exception seen, data not back yet
    input  logic                npc_flow,    // fs_pc just moved, may advance
    input  logic                mfc0_stall,  // cp0 read in flight, hold branch
    input  fetch_pkg::addr_t    epc,
    input  fetch_pkg::br_bus_t  br_bus,
    input  fetch_pkg::addr_t    fs_pc,
    output fetch_pkg::addr_t    nextpc,
    output logic                nextpc_misaligned
);

    fetch_pkg::addr_t seq_pc;
    fetch_pkg::addr_t nextpc_timely;  // fresh pick of this cycle
    fetch_pkg::addr_t nextpc_buf;     // last pick, held for the memory port
    logic             br_go;
    logic             npc_update;

    assign seq_pc = fs_pc + 32'd4;

    // branch only counts when decode has it resolved
    assign br_go = br_bus.br_taken & ~br_bus.br_stall & ~mfc0_stall;

    // cycles in which the pick is live
    assign npc_update = eret | flush | flush_pend | npc_flow;

    // eret over exception over branch over sequential
    always_comb begin
        if (eret) begin
            nextpc_timely = epc;
        end else if (flush | flush_pend) begin
            nextpc_timely = fetch_pkg::EXC_VECTOR;
        end else if (br_go) begin
            nextpc_timely = br_bus.br_target;
        end else begin
            nextpc_timely = seq_pc;
        end
    end

    // buffer starts at the boot address so the first request needs no flow
    always_ff @(posedge clk) begin
        if (reset) begin
            nextpc_buf <= fetch_pkg::RESET_PC + 32'd4;
        end else if (npc_update) begin
            nextpc_buf <= nextpc_timely;
        end
    end

    // live pick when something moved, else the held one
    assign nextpc = npc_update ? nextpc_timely : nextpc_buf;

    // word fetch only, low bits must be zero
    assign nextpc_misaligned = (nextpc[1:0] != 2'b00);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_fetch_top -f sources.f -o sim_fetch

./obj_dir/sim_fetch | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: sources.f
+incdir+tb
rtl/fetch_pkg.sv
rtl/next_pc_unit.sv
rtl/fetch_ctrl.sv
rtl/fetch_out_stage.sv
rtl/inst_rom.sv
rtl/fetch_top.sv
tb/tb_fetch_top.sv

// File: tb/tb_fetch_table.svh
`ifndef TB_FETCH_TABLE_SVH
`define TB_FETCH_TABLE_SVH

// redirect applied in a step
localparam logic [1:0] STEP_NONE   = 2'd0;
localparam logic [1:0] STEP_BRANCH = 2'd1;
localparam logic [1:0] STEP_FLUSH  = 2'd2;
localparam logic [1:0] STEP_ERET   = 2'd3;

typedef struct packed {
    logic [1:0]           kind;
    logic                 also_flush;  // eret raised together with flush
    logic                 br_stall;
    logic                 mfc0;        // mfc0_stall during the branch
    logic                 gaps;        // random allow-in gaps
    fetch_pkg::addr_t     target;      // br_target, or epc for eret
    fetch_pkg::exc_code_t exp_exc;     // code expected on this step's item
} step_t;

localparam int NUM_STEPS = 32;

// kind, also_flush, br_stall, mfc0, gaps, target, expected code
localparam step_t STEPS [0:NUM_STEPS-1] = '{
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b0, 1'b0, 32'hbfc00040, fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b1, 1'b0, 1'b0, 32'hbfc00100, fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b1, 1'b0, 32'hbfc00100, fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_FLUSH,  1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_ERET,   1'b0, 1'b0, 1'b0, 1'b0, 32'hbfc00020, fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_ERET,   1'b1, 1'b0, 1'b0, 1'b0, 32'hbfc00060, fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b0, 1'b0, 32'hbfc00012, fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b0, 1'b0, 32'hbfc00030, fetch_pkg::EXC_ADEL},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b0, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b0, 1'b1, 32'hbfc00070, fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_FLUSH,  1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_ERET,   1'b0, 1'b0, 1'b0, 1'b1, 32'hbfc00010, fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b0, 1'b1, 32'hbfc00006, fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b0, 1'b0, 1'b1, 32'hbfc00050, fetch_pkg::EXC_ADEL},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_BRANCH, 1'b0, 1'b1, 1'b0, 1'b1, 32'hbfc00200, fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE},
    '{STEP_NONE,   1'b0, 1'b0, 1'b0, 1'b1, 32'h0,        fetch_pkg::EXC_NONE}
};

`endif

// File: tb/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    `include "tb_fetch_table.svh"

    localparam int TIMEOUT_CYCLES = 100;

    logic                 clk;
    logic                 reset;
    fetch_pkg::br_bus_t   br_bus;
    logic                 flush;
    logic                 eret;
    fetch_pkg::addr_t     epc;
    logic                 mfc0_stall;
    logic                 ds_allowin;
    logic                 fs_to_ds_valid;
    fetch_pkg::fs_to_ds_t fs_to_ds_bus;

    fetch_pkg::inst_t     image [0:fetch_pkg::ROM_WORDS-1];  // own copy of the rom image
    fetch_pkg::addr_t     pick;         // pc the model picks for the next item
    logic                 gaps_on;
    logic                 held;         // item was stalled last cycle
    fetch_pkg::fs_to_ds_t held_bus;
    int                   value_errors;
    int                   other_errors;

    fetch_top UUT (
        .clk            (clk),
        .reset          (reset),
        .br_bus         (br_bus),
        .flush          (flush),
        .eret           (eret),
        .epc            (epc),
        .mfc0_stall     (mfc0_stall),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic check_addr(input fetch_pkg::addr_t got, input fetch_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_exc(input fetch_pkg::exc_code_t got, input fetch_pkg::exc_code_t exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // inputs change only on the rising edge
    task automatic apply_step(input step_t s);
        br_bus.bd        <= (s.kind == STEP_BRANCH);  // decode flags the slot behind its branch
        br_bus.br_taken  <= (s.kind == STEP_BRANCH);
        br_bus.br_stall  <= s.br_stall;
        br_bus.br_target <= (s.kind == STEP_BRANCH) ? s.target : '0;
        mfc0_stall       <= s.mfc0;
        flush            <= (s.kind == STEP_FLUSH) | ((s.kind == STEP_ERET) & s.also_flush);
        eret             <= (s.kind == STEP_ERET);
        if (s.kind == STEP_ERET) begin
            epc <= s.target;
        end
        gaps_on <= s.gaps;
    endtask

    // item handed over when valid and allow-in meet
    task automatic wait_item(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
            @(negedge clk);
            if (fs_to_ds_valid && ds_allowin) begin
                ok = 1'b1;
            end
        end
    endtask

    // random decode back-pressure in gap steps only
    initial begin
        void'($urandom(72612));
        ds_allowin = 1'b1;
        forever begin
            @(posedge clk);
            ds_allowin <= gaps_on ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    // stalled item must not move
    always @(negedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else begin
            if (held) begin
                if (!fs_to_ds_valid) begin
                    other_errors++;
                    $display("valid dropped at %0t while decode was stalled", $time);
                end
                check_addr(fs_to_ds_bus.pc, held_bus.pc, "held pc");
                check_inst(fs_to_ds_bus.inst, held_bus.inst, "held inst");
                check_exc(fs_to_ds_bus.exc_code, held_bus.exc_code, "held exc_code");
                check_flag(fs_to_ds_bus.ex, held_bus.ex, "held ex");
                check_flag(fs_to_ds_bus.bd, held_bus.bd, "held bd");
            end
            held     = fs_to_ds_valid && !ds_allowin;
            held_bus = fs_to_ds_bus;
        end
    end

    initial begin
        step_t            s;
        fetch_pkg::addr_t exp_pc;
        fetch_pkg::inst_t exp_inst;
        logic             exp_zero;
        logic             exp_bd;
        logic             bad_align;
        logic             ok;
        value_errors = 0;
        other_errors = 0;
        reset        = 1'b1;
        br_bus       = '0;
        flush        = 1'b0;
        eret         = 1'b0;
        epc          = '0;
        mfc0_stall   = 1'b0;
        gaps_on      = 1'b0;
        $readmemh("rtl/inst_rom.hex", image);
        pick = fetch_pkg::RESET_PC + 32'd4;  // boot address
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag(fs_to_ds_valid, 1'b0, "valid after reset");
        for (int i = 0; i < NUM_STEPS; i++) begin
            s = STEPS[i];
            @(posedge clk);  // edge that took the previous item
            apply_step(s);
            if (s.kind == STEP_FLUSH || s.kind == STEP_ERET) begin
                @(posedge clk);  // one-cycle pulse
                flush <= 1'b0;
                eret  <= 1'b0;
            end
            wait_item(ok);
            if (!ok) begin
                other_errors++;
                $display("timed out at %0t waiting for item of step %0d", $time, i);
                break;
            end
            // model of the next-pc priority
            exp_zero = 1'b0;
            case (s.kind)
                STEP_FLUSH: begin
                    exp_pc   = fetch_pkg::EXC_VECTOR;
                    exp_zero = 1'b1;  // word of the flushed request
                    pick     = fetch_pkg::EXC_VECTOR;
                end
                STEP_ERET: begin
                    exp_pc = s.target;
                    pick   = s.target + 32'd4;
                end
                default: begin
                    exp_pc = pick;
                    if (s.kind == STEP_BRANCH && !s.br_stall && !s.mfc0) begin
                        pick = s.target;
                    end else begin
                        pick = exp_pc + 32'd4;
                    end
                end
            endcase
            exp_bd    = (s.kind == STEP_BRANCH);  // item of a branch step is its slot
            bad_align = (exp_pc[1:0] != 2'b00);
            exp_inst  = (bad_align || exp_zero) ? '0 : image[exp_pc[6:2]];
            check_addr(fs_to_ds_bus.pc, exp_pc, $sformatf("step %0d pc", i));
            check_inst(fs_to_ds_bus.inst, exp_inst, $sformatf("step %0d inst", i));
            check_exc(fs_to_ds_bus.exc_code, s.exp_exc, $sformatf("step %0d exc_code", i));
            check_flag(fs_to_ds_bus.ex, bad_align, $sformatf("step %0d ex", i));
            check_flag(fs_to_ds_bus.bd, exp_bd, $sformatf("step %0d bd", i));
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
